/* sim.f */
+incdir+src
src/game_types_pkg.sv
src/game_state_pkg.sv
src/game_ctrl_if.sv
src/mod_counter.sv
src/press_detector.sv
src/sequence_rom.sv
src/game_datapath.sv
src/game_controller.sv
src/memory_game.sv
sim/memory_game_tb.sv

/* sim/memory_game_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_game_tb
    import game_types_pkg::*;
();

    // Game sizes and timing, in cycles
    localparam int seq_length   = 16;
    localparam int show_period  = 1000;
    localparam int play_timeout = 4000;
    localparam int easy_rounds  = 8;

    logic    clock;
    logic    reset;
    logic    start;
    logic    hard_mode;
    button_t buttons;
    button_t leds;
    logic    won;
    logic    lost;
    logic    done;
    logic    timed_out;

    int          error_count;
    int          check_count;
    logic [31:0] rng_state;

    memory_game memory_game_inst (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .hard_mode (hard_mode),
        .buttons   (buttons),
        .leds      (leds),
        .won       (won),
        .lost      (lost),
        .done      (done),
        .timed_out (timed_out)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // --------------------
    // Reference model
    // --------------------

    // Expected sequence, one-hot masks
    function automatic button_t expected_step(input int index);
        case (index)
            0, 6, 7, 14:   return 4'b0001;
            1, 5, 8, 9:    return 4'b0010;
            2, 4, 10, 11:  return 4'b0100;
            3, 12, 13:     return 4'b1000;
            default:       return 4'b0100;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Advances the generator, upper bits are the better ones
    function automatic int random_below(input int bound);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[30:16]) % bound;
    endfunction

    // --------------------
    // Checks
    // --------------------

    task automatic check_leds(input button_t actual, input button_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s leds %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input bit actual, input bit expected, input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Compares all four outcome outputs at once
    task automatic check_outcome(input bit exp_won, input bit exp_lost,
                                 input bit exp_timed_out, input bit exp_done);
        check_count++;
        if ({won, lost, timed_out, done} !== {exp_won, exp_lost, exp_timed_out, exp_done}) begin
            error_count++;
            $display("CHECK FAILED at %0t: won/lost/timed_out/done %b%b%b%b, expected %b%b%b%b",
                     $time, won, lost, timed_out, done,
                     exp_won, exp_lost, exp_timed_out, exp_done);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(negedge clock);
        reset = 1'b0;
    endtask

    // Start pulse, outputs must drop in prepare
    task automatic start_game(input bit hard);
        hard_mode = hard;
        start     = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_outcome(1'b0, 1'b0, 1'b0, 1'b0);
        check_leds(leds, 4'b0000, "prepare");
    endtask

    // Records each lit step, returns on the fall of the last one
    task automatic capture_show(input int steps);
        button_t shown [seq_length];
        button_t prev;
        int      captured;
        int      lit;
        int      cycles;
        int      limit;
        prev     = '0;
        captured = 0;
        lit      = 0;
        cycles   = 0;
        limit    = steps * (show_period + 1) + 50;
        while ((captured < steps || prev != 0) && cycles < limit) begin
            @(negedge clock);
            cycles++;
            if (leds != 0 && prev == 0 && captured < steps) begin
                shown[captured] = leds;
                captured++;
            end
            if (leds != 0) begin
                lit++;
            end else if (prev != 0) begin
                // Lit for the first half of the period only
                check_flag(lit == show_period / 2, 1'b1, "step lit for half a period");
                lit = 0;
            end
            prev = leds;
        end
        if (cycles >= limit) begin
            error_count++;
            $display("ERROR at %0t: show phase did not finish, %0d of %0d steps seen",
                     $time, captured, steps);
        end
        for (int i = 0; i < captured; i++) begin
            check_leds(shown[i], expected_step(i), $sformatf("shown step %0d", i));
        end
    endtask

    // Gap of the last step, next_show and start_play
    task automatic wait_for_play();
        repeat (show_period / 2 + 4) @(negedge clock);
    endtask

    // Raise, hold six cycles, release
    task automatic press_pattern(input button_t pattern);
        int delay;
        delay = 4 + random_below(16);
        repeat (delay) @(negedge clock);
        buttons = pattern;
        // Press at two cycles, stored at four
        repeat (4) @(negedge clock);
        check_leds(leds, pattern, "stored play echo");
        repeat (2) @(negedge clock);
        buttons = '0;
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            error_count++;
            $display("ERROR at %0t: game did not end within %0d cycles", $time, limit);
        end
    endtask

    task automatic play_round(input int steps);
        capture_show(steps);
        wait_for_play();
        for (int i = 0; i < steps; i++) begin
            press_pattern(expected_step(i));
        end
    endtask

    // Every round but the last must leave the game running
    task automatic play_game(input bit hard, input int rounds);
        start_game(hard);
        for (int r = 1; r <= rounds; r++) begin
            play_round(r);
            if (r < rounds) begin
                check_flag(done, 1'b0, $sformatf("done after round %0d", r));
            end
        end
        wait_for_done(20);
        check_outcome(1'b1, 1'b0, 1'b0, 1'b1);
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic after_reset_idle();
        check_outcome(1'b0, 1'b0, 1'b0, 1'b0);
        check_leds(leds, 4'b0000, "after reset");
        repeat (20) begin
            @(negedge clock);
            check_outcome(1'b0, 1'b0, 1'b0, 1'b0);
            check_leds(leds, 4'b0000, "idle without start");
        end
    endtask

    task automatic easy_game_won();
        play_game(1'b0, easy_rounds);
    endtask

    task automatic hard_game_won();
        play_game(1'b1, seq_length);
    endtask

    // Third round, last step wrong
    task automatic wrong_press_loses();
        button_t wrong;
        start_game(1'b0);
        play_round(1);
        play_round(2);
        capture_show(3);
        wait_for_play();
        press_pattern(expected_step(0));
        press_pattern(expected_step(1));
        wrong = button_t'(random_below(15) + 1);
        if (wrong == expected_step(2)) begin
            wrong = ~wrong;
        end
        press_pattern(wrong);
        wait_for_done(20);
        check_outcome(1'b0, 1'b1, 1'b0, 1'b1);
    endtask

    // Count from the fall of the only shown step
    task automatic no_press_times_out();
        int cycles;
        start_game(1'b0);
        capture_show(1);
        cycles = 0;
        while (!done && cycles < play_timeout + show_period / 2 + 50) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            error_count++;
            $display("ERROR at %0t: no timeout after %0d cycles without a press", $time, cycles);
        end
        // Dark half of the step still to run, then the whole wait
        check_flag(cycles >= play_timeout + show_period / 2, 1'b1, "timeout not early");
        check_outcome(1'b0, 1'b0, 1'b1, 1'b1);
    endtask

    // From timeout, then from a loss
    task automatic restart_from_end();
        start_game(1'b0);
        capture_show(1);
        wait_for_play();
        press_pattern(~expected_step(0));
        wait_for_done(20);
        check_outcome(1'b0, 1'b1, 1'b0, 1'b1);
        start_game(1'b0);
        capture_show(1);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        hard_mode   = 1'b0;
        buttons     = '0;
        error_count = 0;
        check_count = 0;
        rng_state   = 32'h6fbf;

        apply_reset();
        after_reset_idle();
        easy_game_won();
        // Each later game starts from the end state left behind
        hard_game_won();
        wrong_press_loses();
        no_press_times_out();
        restart_from_end();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/game_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module game_controller
    import game_state_pkg::*;
(
    input  wire             clock,
    input  wire             reset,
    input  wire             start,
    input  wire             hard_mode,
    game_ctrl_if.controller ctrl,
    output logic            won,
    output logic            lost,
    output logic            done,
    output logic            timed_out
);

    game_state_t state;
    game_state_t next_state;
    logic        hard_game;

    // --------------------
    // State and mode registers
    // --------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Mode switch held for the whole game
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hard_game <= 1'b0;
        end else if (state == prepare) begin
            hard_game <= hard_mode;
        end
    end

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        next_state = state;
        case (state)
            idle:       next_state = start ? prepare : idle;
            prepare:    next_state = show_step;
            // Show phase, one step per period
            show_step:  next_state = ctrl.show_half ? show_gap : show_step;
            show_gap:   next_state = ctrl.show_end ? next_show : show_gap;
            next_show:  next_state = ctrl.address_at_round ? start_play : show_step;
            start_play: next_state = wait_play;
            // Press beats timeout in the same cycle
            wait_play: begin
                if (ctrl.press) begin
                    next_state = store_play;
                end else if (ctrl.play_timeout) begin
                    next_state = end_timeout;
                end
            end
            store_play: next_state = compare_play;
            compare_play: begin
                if (ctrl.play_match && ctrl.address_below_round) begin
                    next_state = next_play;
                end else if (ctrl.play_match && ctrl.address_at_round) begin
                    next_state = last_round_check;
                end else begin
                    next_state = end_lost;
                end
            end
            next_play: next_state = wait_play;
            // Easy game ends halfway through the table
            last_round_check: begin
                if (ctrl.round_last || (ctrl.round_half && !hard_game)) begin
                    next_state = end_won;
                end else begin
                    next_state = next_round;
                end
            end
            next_round:  next_state = show_step;
            // End states wait for a new start
            end_timeout: next_state = start ? prepare : end_timeout;
            end_won:     next_state = start ? prepare : end_won;
            end_lost:    next_state = start ? prepare : end_lost;
            default:     next_state = idle;
        endcase
    end

    // --------------------
    // Moore outputs
    // --------------------

    assign ctrl.clear_address = (state == idle) || (state == prepare) ||
                                (state == start_play) || (state == next_round);
    assign ctrl.step_address  = (state == next_show) || (state == next_play);
    assign ctrl.clear_round   = (state == idle) || (state == prepare);
    assign ctrl.step_round    = (state == next_round);
    assign ctrl.clear_show    = (state == idle) || (state == prepare) ||
                                (state == next_show) || (state == next_round);
    assign ctrl.step_show     = (state == show_step) || (state == show_gap);
    assign ctrl.clear_play    = (state == idle) || (state == prepare);
    assign ctrl.store_play    = (state == store_play);
    assign ctrl.wait_play     = (state == wait_play);

    // Stored play echoed while it is judged
    always_comb begin
        case (state)
            show_step:        ctrl.led_source = led_sequence;
            compare_play,
            next_play,
            last_round_check: ctrl.led_source = led_play;
            default:          ctrl.led_source = led_off;
        endcase
    end

    // Outcome flags
    assign won       = (state == end_won);
    assign lost      = (state == end_lost);
    assign timed_out = (state == end_timeout);
    assign done      = won || lost || timed_out;

    // At most one outcome at a time
    outcome_exclusive: assert property (@(posedge clock) disable iff (reset)
        $onehot0({won, lost, timed_out}));

endmodule

`default_nettype wire

/* src/game_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface game_ctrl_if
    import game_state_pkg::*;
();

    // Strobes from the controller
    logic        clear_address;
    logic        step_address;
    logic        clear_round;
    logic        step_round;
    logic        clear_show;
    logic        step_show;
    logic        clear_play;
    logic        store_play;
    logic        wait_play;    // level, also runs the timeout timer
    led_source_t led_source;

    // Status flags from the datapath
    logic        play_match;
    logic        address_at_round;
    logic        address_below_round;
    logic        round_half;
    logic        round_last;
    logic        show_half;
    logic        show_end;
    logic        press;
    logic        play_timeout;

    modport controller (
        output clear_address, step_address, clear_round, step_round,
        output clear_show, step_show, clear_play, store_play, wait_play, led_source,
        input  play_match, address_at_round, address_below_round,
        input  round_half, round_last, show_half, show_end, press, play_timeout
    );

    modport datapath (
        input  clear_address, step_address, clear_round, step_round,
        input  clear_show, step_show, clear_play, store_play, wait_play, led_source,
        output play_match, address_at_round, address_below_round,
        output round_half, round_last, show_half, show_end, press, play_timeout
    );

endinterface

`default_nettype wire

/* src/game_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "game_macros.svh"

module game_datapath
    import game_types_pkg::*;
    import game_state_pkg::*;
(
    input  wire           clock,
    input  wire           reset,
    input  wire  button_t buttons,
    game_ctrl_if.datapath ctrl,
    output button_t       leds
);

    address_t address;
    address_t round;
    address_t rom_address;
    button_t  rom_data;
    button_t  play_word;

    // --------------------
    // Counters
    // --------------------

    // Current step, in the show and in the play
    mod_counter #(.modulus(`SEQ_LENGTH)) address_counter (
        .clock   (clock),
        .reset   (reset),
        .clear   (ctrl.clear_address),
        .step    (ctrl.step_address),
        .count   (address),
        .at_end  (),
        .at_half ()
    );

    // Last step index of this round
    mod_counter #(.modulus(`SEQ_LENGTH)) round_counter (
        .clock   (clock),
        .reset   (reset),
        .clear   (ctrl.clear_round),
        .step    (ctrl.step_round),
        .count   (round),
        .at_end  (ctrl.round_last),
        .at_half ()
    );

    // Lit half then dark half of each shown step
    mod_counter #(.modulus(`SHOW_PERIOD)) show_timer (
        .clock   (clock),
        .reset   (reset),
        .clear   (ctrl.clear_show),
        .step    (ctrl.step_show),
        .count   (),
        .at_end  (ctrl.show_end),
        .at_half (ctrl.show_half)
    );

    // Runs only while waiting for a press
    mod_counter #(.modulus(`PLAY_TIMEOUT)) timeout_timer (
        .clock   (clock),
        .reset   (reset),
        .clear   (!ctrl.wait_play),
        .step    (ctrl.wait_play),
        .count   (),
        .at_end  (ctrl.play_timeout),
        .at_half ()
    );

    // --------------------
    // Sequence and buttons
    // --------------------

    // Look one address ahead so the ROM word is ready on the first cycle of a step
    assign rom_address = ctrl.clear_address ? '0 :
                         ctrl.step_address  ? address_t'(address + 1'b1) : address;

    sequence_rom sequence_rom_inst (
        .clock   (clock),
        .address (rom_address),
        .data    (rom_data)
    );

    press_detector press_detector_inst (
        .clock   (clock),
        .reset   (reset),
        .buttons (buttons),
        .press   (ctrl.press)
    );

    // Play register, captures the held pattern
    always_ff @(posedge clock) begin
        if (ctrl.clear_play) begin
            play_word <= '0;
        end else if (ctrl.store_play) begin
            play_word <= buttons;
        end
    end

    // --------------------
    // Compare and LED select
    // --------------------

    assign ctrl.play_match          = (play_word == rom_data);
    assign ctrl.address_at_round    = (address == round);
    assign ctrl.address_below_round = (address < round);
    assign ctrl.round_half          = (round == address_t'(`EASY_ROUNDS - 1));

    always_comb begin
        case (ctrl.led_source)
            led_sequence: leds = rom_data;
            led_play:     leds = play_word;
            default:      leds = '0;
        endcase
    end

    // Every step of the table lights exactly one button
    rom_one_hot: assert property (@(posedge clock) disable iff (reset)
        $onehot(rom_data));

endmodule

`default_nettype wire

/* src/game_macros.svh */
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// --------------------
// Sequence
// --------------------

// Steps held in the ROM, also the longest game
`define SEQ_LENGTH 16

// Rounds for a win in easy mode
`define EASY_ROUNDS 8

// --------------------
// Timing, in clock cycles
// --------------------

// One shown step, LED lit for the first half
`define SHOW_PERIOD 1000

// Longest wait for a press
`define PLAY_TIMEOUT 4000

`endif

/* src/game_state_pkg.sv */
`default_nettype none

package game_state_pkg;

    // --------------------
    // Controller states
    // --------------------

    typedef enum logic [3:0] {
        idle             = 4'h0,
        prepare          = 4'h1,
        next_show        = 4'h2,
        wait_play        = 4'h3,
        store_play       = 4'h4,
        compare_play     = 4'h5,
        next_play        = 4'h6,
        last_round_check = 4'h7,
        next_round       = 4'h8,
        show_step        = 4'h9,
        show_gap         = 4'ha,
        start_play       = 4'hb,
        // 4'hc unused
        end_timeout      = 4'hd,
        end_won          = 4'he,
        end_lost         = 4'hf
    } game_state_t;

    // --------------------
    // LED source select
    // --------------------

    typedef enum logic [1:0] {
        led_off      = 2'd0,
        led_sequence = 2'd1,
        led_play     = 2'd2
    } led_source_t;

endpackage

`default_nettype wire

/* src/game_types_pkg.sv */
`default_nettype none

`include "game_macros.svh"

package game_types_pkg;

    // --------------------
    // Data words
    // --------------------

    // One bit per button, same order as the LEDs
    typedef logic [3:0] button_t;

    // ROM address, also used for the round number
    typedef logic [$clog2(`SEQ_LENGTH)-1:0] address_t;

endpackage

`default_nettype wire

/* src/memory_game.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_game
    import game_types_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire          start,
    input  wire          hard_mode,
    input  wire button_t buttons,
    output button_t      leds,
    output logic         won,
    output logic         lost,
    output logic         done,
    output logic         timed_out
);

    // Strobes down, flags up
    game_ctrl_if ctrl ();

    // --------------------
    // Control
    // --------------------

    game_controller game_controller_inst (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .hard_mode (hard_mode),
        .ctrl      (ctrl.controller),
        .won       (won),
        .lost      (lost),
        .done      (done),
        .timed_out (timed_out)
    );

    // --------------------
    // Datapath
    // --------------------

    game_datapath game_datapath_inst (
        .clock   (clock),
        .reset   (reset),
        .buttons (buttons),
        .ctrl    (ctrl.datapath),
        .leds    (leds)
    );

endmodule

`default_nettype wire

/* src/mod_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module mod_counter #(
    parameter  int modulus = 16,
    localparam int width   = (modulus > 1) ? $clog2(modulus) : 1
) (
    input  wire              clock,
    input  wire              reset,
    input  wire              clear,
    input  wire              step,
    output logic [width-1:0] count,
    output logic             at_end,
    output logic             at_half
);

    // --------------------
    // Count register
    // --------------------

    // Clear wins over step
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            // Wrap back to zero after the last value
            if (at_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Flags decode the count directly
    assign at_end  = (count == width'(modulus - 1));
    assign at_half = (count == width'(modulus / 2 - 1));

    // Count never leaves the modulus range
    count_in_range: assert property (@(posedge clock) disable iff (reset)
        int'(count) < modulus);

endmodule

`default_nettype wire

/* src/press_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module press_detector
    import game_types_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire button_t buttons,
    output logic         press
);

    logic any_button;
    logic stage_0;
    logic stage_1;

    // Any button raised counts as a press
    assign any_button = |buttons;

    // Two sync stages, then a registered rising-edge pulse
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage_0 <= 1'b0;
            stage_1 <= 1'b0;
            press   <= 1'b0;
        end else begin
            stage_0 <= any_button;
            stage_1 <= stage_0;
            press   <= stage_0 & ~stage_1;   // one cycle wide
        end
    end

endmodule

`default_nettype wire

/* src/sequence_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module sequence_rom
    import game_types_pkg::*;
(
    input  wire           clock,
    input  wire address_t address,
    output button_t       data
);

    // Fixed game sequence, one-hot button masks
    // Data valid one clock after the address
    always_ff @(posedge clock) begin
        case (address)
            4'd0:    data <= 4'b0001;
            4'd1:    data <= 4'b0010;
            4'd2:    data <= 4'b0100;
            4'd3:    data <= 4'b1000;
            4'd4:    data <= 4'b0100;
            4'd5:    data <= 4'b0010;
            4'd6:    data <= 4'b0001;
            4'd7:    data <= 4'b0001;
            4'd8:    data <= 4'b0010;
            4'd9:    data <= 4'b0010;
            4'd10:   data <= 4'b0100;
            4'd11:   data <= 4'b0100;
            4'd12:   data <= 4'b1000;
            4'd13:   data <= 4'b1000;
            4'd14:   data <= 4'b0001;
            default: data <= 4'b0100;
        endcase
    end

endmodule

`default_nettype wire
